// File: verilog/xbar_geom_pkg.sv
// tile array size, coordinate and port index types, coordinate to index conversions
package xbar_geom_pkg;

  localparam int num_x_lp = 2;
  localparam int num_y_lp = 2;
  localparam int num_ports_lp = num_x_lp * num_y_lp;

  localparam int x_cord_width_lp = 1;
  localparam int y_cord_width_lp = 1;
  localparam int port_idx_width_lp = $clog2(num_ports_lp);

  typedef logic [x_cord_width_lp-1:0] x_cord_t;
  typedef logic [y_cord_width_lp-1:0] y_cord_t;
  // y above x, as the coordinates sit in a packet
  typedef logic [y_cord_width_lp+x_cord_width_lp-1:0] cord_t;
  typedef logic [port_idx_width_lp-1:0] port_idx_t;

  // row-major flat index
  function automatic port_idx_t cord_to_idx(input cord_t cord);
    y_cord_t y;
    x_cord_t x;
    {y, x} = cord;
    return port_idx_t'(int'(y) * num_x_lp + int'(x));
  endfunction

  function automatic cord_t idx_to_cord(input port_idx_t idx);
    y_cord_t y;
    x_cord_t x;
    y = y_cord_t'(int'(idx) / num_x_lp);
    x = x_cord_t'(int'(idx) % num_x_lp);
    return {y, x};
  endfunction

endpackage

// File: verilog/xbar_pkt_pkg.sv
// packet field widths, crossbar word widths, forward and reverse packet types
package xbar_pkt_pkg;

  localparam int addr_width_lp = 8;
  localparam int data_width_lp = 16;

  // request opcode and return type fields
  localparam int fwd_op_width_lp = 2;
  localparam int rev_type_width_lp = 2;

  // y and x together
  localparam int cord_width_lp = $bits(xbar_geom_pkg::cord_t);

  // fwd: op, addr, data, src y/x, dst y/x in the lowest bits
  localparam int fwd_pkt_width_lp =
    fwd_op_width_lp + addr_width_lp + data_width_lp + 2 * cord_width_lp;
  // rev: type, data, dst y/x in the lowest bits
  localparam int rev_pkt_width_lp = rev_type_width_lp + data_width_lp + cord_width_lp;

  // coordinates swapped for the flat index inside the crossbar
  localparam int fwd_xbar_width_lp =
    fwd_pkt_width_lp - cord_width_lp + $bits(xbar_geom_pkg::port_idx_t);
  localparam int rev_xbar_width_lp =
    rev_pkt_width_lp - cord_width_lp + $bits(xbar_geom_pkg::port_idx_t);

  typedef logic [fwd_pkt_width_lp-1:0] fwd_pkt_t;
  typedef logic [rev_pkt_width_lp-1:0] rev_pkt_t;

endpackage

// File: verilog/link_to_crossbar.sv
// link adapter: destination coordinates to port index on entry, index back to coordinates on exit
`timescale 1ns/1ps

module link_to_crossbar #(
  parameter int width_p = 30,
  localparam int xbar_width_lp = width_p - $bits(xbar_geom_pkg::cord_t)
                                 + $bits(xbar_geom_pkg::port_idx_t)
) (
  // tile side, entering
  input  logic [xbar_geom_pkg::num_ports_lp-1:0]                    in_valid_i,
  input  logic [xbar_geom_pkg::num_ports_lp-1:0][width_p-1:0]       in_data_i,
  output logic [xbar_geom_pkg::num_ports_lp-1:0]                    in_ready_o,
  // crossbar side, entering
  output logic [xbar_geom_pkg::num_ports_lp-1:0]                    xbar_valid_o,
  output logic [xbar_geom_pkg::num_ports_lp-1:0][xbar_width_lp-1:0] xbar_data_o,
  input  logic [xbar_geom_pkg::num_ports_lp-1:0]                    xbar_ready_i,
  // crossbar side, leaving
  input  logic [xbar_geom_pkg::num_ports_lp-1:0]                    xbar_valid_i,
  input  logic [xbar_geom_pkg::num_ports_lp-1:0][xbar_width_lp-1:0] xbar_data_i,
  output logic [xbar_geom_pkg::num_ports_lp-1:0]                    xbar_ready_o,
  // tile side, leaving
  output logic [xbar_geom_pkg::num_ports_lp-1:0]                    out_valid_o,
  output logic [xbar_geom_pkg::num_ports_lp-1:0][width_p-1:0]       out_data_o,
  input  logic [xbar_geom_pkg::num_ports_lp-1:0]                    out_ready_i
);

  import xbar_geom_pkg::*;

  // handshakes pass straight through
  assign xbar_valid_o = in_valid_i;
  assign in_ready_o   = xbar_ready_i;
  assign out_valid_o  = xbar_valid_i;
  assign xbar_ready_o = out_ready_i;

  for (genvar p = 0; p < num_ports_lp; p++) begin : g_port
    // entry: body kept, low coordinates replaced by index
    assign xbar_data_o[p] = {
      in_data_i[p][width_p-1:$bits(cord_t)],
      cord_to_idx(in_data_i[p][$bits(cord_t)-1:0])
    };

    // exit: index turned back into coordinates
    assign out_data_o[p] = {
      xbar_data_i[p][xbar_width_lp-1:$bits(port_idx_t)],
      idx_to_cord(xbar_data_i[p][$bits(port_idx_t)-1:0])
    };
  end

endmodule

// File: verilog/rr_arbiter.sv
// round-robin arbiter over the crossbar ports, pointer moves on completed transfer
`timescale 1ns/1ps

module rr_arbiter (
  input  logic                                   clk_i,
  input  logic                                   rst_n_i,
  input  logic [xbar_geom_pkg::num_ports_lp-1:0] req_i,
  output logic [xbar_geom_pkg::num_ports_lp-1:0] grant_o,
  input  logic                                   advance_i
);

  import xbar_geom_pkg::*;

  port_idx_t last_q;
  port_idx_t hold_idx_q;
  logic      hold_q;
  port_idx_t cand;
  port_idx_t win_idx;
  logic      found;

  always_comb begin
    grant_o = '0;
    win_idx = last_q;
    found   = 1'b0;
    cand    = last_q;
    if (hold_q) begin
      // stalled winner keeps the output until it transfers
      found   = 1'b1;
      win_idx = hold_idx_q;
    end else begin
      // scan starts just after the last winner, wraps around to it
      for (int k = 1; k <= num_ports_lp; k++) begin
        cand = last_q + port_idx_t'(k);
        if (!found && req_i[cand]) begin
          found   = 1'b1;
          win_idx = cand;
        end
      end
    end
    if (found) begin
      grant_o[win_idx] = 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      // port 0 comes first after reset
      last_q <= port_idx_t'(num_ports_lp - 1);
      hold_q <= 1'b0;
    end else if (advance_i) begin
      last_q <= win_idx;
      hold_q <= 1'b0;
    end else if (found) begin
      hold_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (found && !advance_i) begin
      hold_idx_q <= win_idx;
    end
  end

endmodule

// File: verilog/crossbar_o_by_i.sv
// crossbar: two-entry queue per input, round-robin arbiter and output mux per output
`timescale 1ns/1ps

module crossbar_o_by_i #(
  parameter int width_p = 30
) (
  input  logic                                              clk_i,
  input  logic                                              rst_n_i,
  input  logic [xbar_geom_pkg::num_ports_lp-1:0]              valid_i,
  input  logic [xbar_geom_pkg::num_ports_lp-1:0][width_p-1:0] data_i,
  output logic [xbar_geom_pkg::num_ports_lp-1:0]              ready_o,
  output logic [xbar_geom_pkg::num_ports_lp-1:0]              valid_o,
  output logic [xbar_geom_pkg::num_ports_lp-1:0][width_p-1:0] data_o,
  input  logic [xbar_geom_pkg::num_ports_lp-1:0]              ready_i
);

  import xbar_geom_pkg::*;

  // queue storage and pointers, one set per input
  logic [width_p-1:0] q_mem [num_ports_lp][2];
  logic [num_ports_lp-1:0] wr_ptr_q;
  logic [num_ports_lp-1:0] rd_ptr_q;
  logic [num_ports_lp-1:0][1:0] count_q;

  logic [num_ports_lp-1:0] push;
  logic [num_ports_lp-1:0] pop;
  logic [num_ports_lp-1:0] head_valid;
  logic [num_ports_lp-1:0][width_p-1:0] head_data;
  port_idx_t [num_ports_lp-1:0] head_dest;

  // indexed [output][input]
  logic [num_ports_lp-1:0][num_ports_lp-1:0] req;
  logic [num_ports_lp-1:0][num_ports_lp-1:0] grant;
  logic [num_ports_lp-1:0] advance;

  for (genvar p = 0; p < num_ports_lp; p++) begin : g_in
    assign ready_o[p]    = (count_q[p] != 2'd2);
    assign push[p]       = valid_i[p] & ready_o[p];
    assign head_valid[p] = (count_q[p] != 2'd0);
    assign head_data[p]  = q_mem[p][rd_ptr_q[p]];
    // flat destination index sits in the low bits
    assign head_dest[p]  = head_data[p][$bits(port_idx_t)-1:0];

    always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
        wr_ptr_q[p] <= 1'b0;
        rd_ptr_q[p] <= 1'b0;
        count_q[p]  <= 2'd0;
      end else begin
        if (push[p]) begin
          wr_ptr_q[p] <= ~wr_ptr_q[p];
        end
        if (pop[p]) begin
          rd_ptr_q[p] <= ~rd_ptr_q[p];
        end
        if (push[p] && !pop[p]) begin
          count_q[p] <= count_q[p] + 2'd1;
        end else if (pop[p] && !push[p]) begin
          count_q[p] <= count_q[p] - 2'd1;
        end
      end
    end

    always_ff @(posedge clk_i) begin
      if (push[p]) begin
        q_mem[p][wr_ptr_q[p]] <= data_i[p];
      end
    end
  end

  for (genvar o = 0; o < num_ports_lp; o++) begin : g_out
    for (genvar p = 0; p < num_ports_lp; p++) begin : g_req
      assign req[o][p] = head_valid[p] && (head_dest[p] == port_idx_t'(o));
    end

    assign valid_o[o] = |grant[o];
    assign advance[o] = valid_o[o] & ready_i[o];

    rr_arbiter arb_i (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .req_i     (req[o]),
      .grant_o   (grant[o]),
      .advance_i (advance[o])
    );

    // one-hot grant, so an or of masked heads is the mux
    always_comb begin
      data_o[o] = '0;
      for (int p = 0; p < num_ports_lp; p++) begin
        if (grant[o][p]) begin
          data_o[o] = data_o[o] | head_data[p];
        end
      end
    end
  end

  // a head leaves when the output that granted it transfers
  always_comb begin
    pop = '0;
    for (int p = 0; p < num_ports_lp; p++) begin
      for (int o = 0; o < num_ports_lp; o++) begin
        pop[p] = pop[p] | (grant[o][p] & advance[o]);
      end
    end
  end

endmodule

// File: verilog/manycore_crossbar.sv
// top level: forward and reverse networks, each an adapter and a crossbar
`timescale 1ns/1ps

module manycore_crossbar (
  input  logic                                                 clk_i,
  input  logic                                                 rst_n_i,
  // forward request network
  input  logic [xbar_geom_pkg::num_ports_lp-1:0]                 fwd_in_valid_i,
  input  xbar_pkt_pkg::fwd_pkt_t [xbar_geom_pkg::num_ports_lp-1:0] fwd_in_data_i,
  output logic [xbar_geom_pkg::num_ports_lp-1:0]                 fwd_in_ready_o,
  output logic [xbar_geom_pkg::num_ports_lp-1:0]                 fwd_out_valid_o,
  output xbar_pkt_pkg::fwd_pkt_t [xbar_geom_pkg::num_ports_lp-1:0] fwd_out_data_o,
  input  logic [xbar_geom_pkg::num_ports_lp-1:0]                 fwd_out_ready_i,
  // reverse return network
  input  logic [xbar_geom_pkg::num_ports_lp-1:0]                 rev_in_valid_i,
  input  xbar_pkt_pkg::rev_pkt_t [xbar_geom_pkg::num_ports_lp-1:0] rev_in_data_i,
  output logic [xbar_geom_pkg::num_ports_lp-1:0]                 rev_in_ready_o,
  output logic [xbar_geom_pkg::num_ports_lp-1:0]                 rev_out_valid_o,
  output xbar_pkt_pkg::rev_pkt_t [xbar_geom_pkg::num_ports_lp-1:0] rev_out_data_o,
  input  logic [xbar_geom_pkg::num_ports_lp-1:0]                 rev_out_ready_i
);

  import xbar_geom_pkg::*;
  import xbar_pkt_pkg::*;

  // fwd
  logic [num_ports_lp-1:0]                        fwd_to_xbar_valid;
  logic [num_ports_lp-1:0][fwd_xbar_width_lp-1:0] fwd_to_xbar_data;
  logic [num_ports_lp-1:0]                        fwd_to_xbar_ready;
  logic [num_ports_lp-1:0]                        fwd_from_xbar_valid;
  logic [num_ports_lp-1:0][fwd_xbar_width_lp-1:0] fwd_from_xbar_data;
  logic [num_ports_lp-1:0]                        fwd_from_xbar_ready;

  link_to_crossbar #(.width_p(fwd_pkt_width_lp)) fwd_link_i (
    .in_valid_i   (fwd_in_valid_i),
    .in_data_i    (fwd_in_data_i),
    .in_ready_o   (fwd_in_ready_o),
    .xbar_valid_o (fwd_to_xbar_valid),
    .xbar_data_o  (fwd_to_xbar_data),
    .xbar_ready_i (fwd_to_xbar_ready),
    .xbar_valid_i (fwd_from_xbar_valid),
    .xbar_data_i  (fwd_from_xbar_data),
    .xbar_ready_o (fwd_from_xbar_ready),
    .out_valid_o  (fwd_out_valid_o),
    .out_data_o   (fwd_out_data_o),
    .out_ready_i  (fwd_out_ready_i)
  );

  crossbar_o_by_i #(.width_p(fwd_xbar_width_lp)) fwd_xbar_i (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (fwd_to_xbar_valid),
    .data_i  (fwd_to_xbar_data),
    .ready_o (fwd_to_xbar_ready),
    .valid_o (fwd_from_xbar_valid),
    .data_o  (fwd_from_xbar_data),
    .ready_i (fwd_from_xbar_ready)
  );

  // rev, independent of fwd
  logic [num_ports_lp-1:0]                        rev_to_xbar_valid;
  logic [num_ports_lp-1:0][rev_xbar_width_lp-1:0] rev_to_xbar_data;
  logic [num_ports_lp-1:0]                        rev_to_xbar_ready;
  logic [num_ports_lp-1:0]                        rev_from_xbar_valid;
  logic [num_ports_lp-1:0][rev_xbar_width_lp-1:0] rev_from_xbar_data;
  logic [num_ports_lp-1:0]                        rev_from_xbar_ready;

  link_to_crossbar #(.width_p(rev_pkt_width_lp)) rev_link_i (
    .in_valid_i   (rev_in_valid_i),
    .in_data_i    (rev_in_data_i),
    .in_ready_o   (rev_in_ready_o),
    .xbar_valid_o (rev_to_xbar_valid),
    .xbar_data_o  (rev_to_xbar_data),
    .xbar_ready_i (rev_to_xbar_ready),
    .xbar_valid_i (rev_from_xbar_valid),
    .xbar_data_i  (rev_from_xbar_data),
    .xbar_ready_o (rev_from_xbar_ready),
    .out_valid_o  (rev_out_valid_o),
    .out_data_o   (rev_out_data_o),
    .out_ready_i  (rev_out_ready_i)
  );

  crossbar_o_by_i #(.width_p(rev_xbar_width_lp)) rev_xbar_i (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (rev_to_xbar_valid),
    .data_i  (rev_to_xbar_data),
    .ready_o (rev_to_xbar_ready),
    .valid_o (rev_from_xbar_valid),
    .data_o  (rev_from_xbar_data),
    .ready_i (rev_from_xbar_ready)
  );

endmodule

// File: tb/crossbar_checker.sv
// crossbar checker: input to output prediction, stall hold, queue occupancy and fairness checks
`timescale 1ns/1ps

module crossbar_checker (
  input  logic                                                   clk_i,
  input  logic                                                   rst_n_i,
  input  logic [xbar_geom_pkg::num_ports_lp-1:0]                 fwd_in_valid_i,
  input  xbar_pkt_pkg::fwd_pkt_t [xbar_geom_pkg::num_ports_lp-1:0] fwd_in_data_i,
  input  logic [xbar_geom_pkg::num_ports_lp-1:0]                 fwd_in_ready_i,
  input  logic [xbar_geom_pkg::num_ports_lp-1:0]                 fwd_out_valid_i,
  input  xbar_pkt_pkg::fwd_pkt_t [xbar_geom_pkg::num_ports_lp-1:0] fwd_out_data_i,
  input  logic [xbar_geom_pkg::num_ports_lp-1:0]                 fwd_out_ready_i,
  input  logic [xbar_geom_pkg::num_ports_lp-1:0]                 rev_in_valid_i,
  input  xbar_pkt_pkg::rev_pkt_t [xbar_geom_pkg::num_ports_lp-1:0] rev_in_data_i,
  input  logic [xbar_geom_pkg::num_ports_lp-1:0]                 rev_in_ready_i,
  input  logic [xbar_geom_pkg::num_ports_lp-1:0]                 rev_out_valid_i,
  input  xbar_pkt_pkg::rev_pkt_t [xbar_geom_pkg::num_ports_lp-1:0] rev_out_data_i,
  input  logic [xbar_geom_pkg::num_ports_lp-1:0]                 rev_out_ready_i,
  output int                                                     mismatch_count_o,
  output int                                                     other_count_o,
  output int                                                     pending_o
);

  import xbar_geom_pkg::*;
  import xbar_pkt_pkg::*;

  localparam int word_width_lp = fwd_pkt_width_lp;

  // expected packets, [network][output][source]
  logic [word_width_lp-1:0] exp_q [2][num_ports_lp][num_ports_lp][$];
  // destinations in order per channel, channel = network * 4 + source
  int dst_q [2*num_ports_lp][$];
  int occ [2*num_ports_lp];
  int wait_cnt [2][num_ports_lp][num_ports_lp];
  logic held_v [2][num_ports_lp];
  logic [word_width_lp-1:0] held_d [2][num_ports_lp];
  logic first_cycle;

  logic [num_ports_lp-1:0][word_width_lp-1:0] fwd_in_w, fwd_out_w, rev_in_w, rev_out_w;

  always_comb begin
    for (int p = 0; p < num_ports_lp; p++) begin
      fwd_in_w[p]  = fwd_in_data_i[p];
      fwd_out_w[p] = fwd_out_data_i[p];
      rev_in_w[p]  = word_width_lp'(rev_in_data_i[p]);
      rev_out_w[p] = word_width_lp'(rev_out_data_i[p]);
    end
  end

  initial begin
    mismatch_count_o = 0;
    other_count_o    = 0;
    pending_o        = 0;
    first_cycle      = 1'b1;
    for (int c = 0; c < 2 * num_ports_lp; c++) begin
      occ[c] = 0;
    end
    for (int n = 0; n < 2; n++) begin
      for (int o = 0; o < num_ports_lp; o++) begin
        held_v[n][o] = 1'b0;
        held_d[n][o] = '0;
        for (int s = 0; s < num_ports_lp; s++) begin
          wait_cnt[n][o][s] = 0;
        end
      end
    end
  end

  task automatic mismatch(input string msg);
    mismatch_count_o++;
    $display("MISMATCH at %0t: %s", $time, msg);
  endtask

  task automatic check_net(input int n,
                           input logic [num_ports_lp-1:0] in_v,
                           input logic [num_ports_lp-1:0] in_r,
                           input logic [num_ports_lp-1:0][word_width_lp-1:0] in_d,
                           input logic [num_ports_lp-1:0] out_v,
                           input logic [num_ports_lp-1:0] out_r,
                           input logic [num_ports_lp-1:0][word_width_lp-1:0] out_d);
    int c;
    int o;
    int hit;
    int head_dst [num_ports_lp];
    // in-ready should follow the two-entry queue fill
    for (int p = 0; p < num_ports_lp; p++) begin
      c = n * num_ports_lp + p;
      head_dst[p] = (dst_q[c].size() > 0) ? dst_q[c][0] : -1;
      if (in_r[p] !== (occ[c] < 2)) begin
        mismatch($sformatf("net %0d in_ready[%0d]=%b with %0d queued", n, p, in_r[p], occ[c]));
      end
    end
    for (int k = 0; k < num_ports_lp; k++) begin
      if (held_v[n][k] && (out_v[k] !== 1'b1 || out_d[k] !== held_d[n][k])) begin
        mismatch($sformatf("net %0d output %0d changed while stalled", n, k));
      end
      held_v[n][k] = out_v[k] & ~out_r[k];
      held_d[n][k] = out_d[k];
    end
    for (int k = 0; k < num_ports_lp; k++) begin
      if (out_v[k] && out_r[k]) begin
        hit = -1;
        for (int s = 0; s < num_ports_lp; s++) begin
          if (hit < 0 && exp_q[n][k][s].size() > 0 && exp_q[n][k][s][0] === out_d[k]) begin
            hit = s;
          end
        end
        if (hit < 0) begin
          mismatch($sformatf("net %0d output %0d got unexpected %h", n, k, out_d[k]));
        end else begin
          c = n * num_ports_lp + hit;
          void'(exp_q[n][k][hit].pop_front());
          void'(dst_q[c].pop_front());
          occ[c]--;
          pending_o--;
          wait_cnt[n][k][hit] = 0;
          // round robin bounds the wait of every requesting head
          for (int s = 0; s < num_ports_lp; s++) begin
            if (s != hit && head_dst[s] == k) begin
              wait_cnt[n][k][s]++;
              if (wait_cnt[n][k][s] > num_ports_lp - 1) begin
                other_count_o++;
                $display("net %0d source %0d waited more than %0d transfers on output %0d",
                         n, s, num_ports_lp - 1, k);
              end
            end
          end
        end
      end
    end
    for (int p = 0; p < num_ports_lp; p++) begin
      if (in_v[p] && in_r[p]) begin
        c = n * num_ports_lp + p;
        // destination index, row major from y and x
        o = int'(in_d[p][1]) * num_x_lp + int'(in_d[p][0]);
        exp_q[n][o][p].push_back(in_d[p]);
        dst_q[c].push_back(o);
        occ[c]++;
        pending_o++;
      end
    end
  endtask

  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      first_cycle = 1'b1;
    end else begin
      if (first_cycle) begin
        if (fwd_out_valid_i !== '0 || rev_out_valid_i !== '0) begin
          mismatch("out_valid high right after reset");
        end
        first_cycle = 1'b0;
      end
      check_net(0, fwd_in_valid_i, fwd_in_ready_i, fwd_in_w,
                fwd_out_valid_i, fwd_out_ready_i, fwd_out_w);
      check_net(1, rev_in_valid_i, rev_in_ready_i, rev_in_w,
                rev_out_valid_i, rev_out_ready_i, rev_out_w);
    end
  end

  task automatic report_leftovers();
    for (int c = 0; c < 2 * num_ports_lp; c++) begin
      if (occ[c] != 0) begin
        other_count_o++;
        $display("%0d packets never delivered from network %0d source %0d",
                 occ[c], c / num_ports_lp, c % num_ports_lp);
      end
    end
  endtask

endmodule

// File: tb/crossbar_tb.sv
// crossbar testbench top: clock, reset, pattern driven sources, random output stalls
`timescale 1ns/1ps

module crossbar_tb;

  import xbar_geom_pkg::*;
  import xbar_pkt_pkg::*;

  localparam int num_patterns_lp = 21;
  localparam int stall_cycles_lp = 40;
  localparam int hold_limit_lp = 200;
  localparam int run_limit_lp = 2000;

  logic clk;
  logic rst_n;
  logic [num_ports_lp-1:0] fwd_in_valid, fwd_in_ready, fwd_out_valid, fwd_out_ready;
  logic [num_ports_lp-1:0] rev_in_valid, rev_in_ready, rev_out_valid, rev_out_ready;
  fwd_pkt_t [num_ports_lp-1:0] fwd_in_data, fwd_out_data;
  rev_pkt_t [num_ports_lp-1:0] rev_in_data, rev_out_data;

  // net nibble, source nibble, packet word
  logic [39:0] patterns [0:num_patterns_lp-1];
  logic [29:0] ch_list [2*num_ports_lp][$];
  int seed;
  int timeout_errors;
  int mismatch_count, other_count, pending;

  manycore_crossbar dut_i (
    .clk_i(clk), .rst_n_i(rst_n),
    .fwd_in_valid_i(fwd_in_valid), .fwd_in_data_i(fwd_in_data), .fwd_in_ready_o(fwd_in_ready),
    .fwd_out_valid_o(fwd_out_valid), .fwd_out_data_o(fwd_out_data),
    .fwd_out_ready_i(fwd_out_ready),
    .rev_in_valid_i(rev_in_valid), .rev_in_data_i(rev_in_data), .rev_in_ready_o(rev_in_ready),
    .rev_out_valid_o(rev_out_valid), .rev_out_data_o(rev_out_data),
    .rev_out_ready_i(rev_out_ready)
  );

  crossbar_checker chk_i (
    .clk_i(clk), .rst_n_i(rst_n),
    .fwd_in_valid_i(fwd_in_valid), .fwd_in_data_i(fwd_in_data), .fwd_in_ready_i(fwd_in_ready),
    .fwd_out_valid_i(fwd_out_valid), .fwd_out_data_i(fwd_out_data),
    .fwd_out_ready_i(fwd_out_ready),
    .rev_in_valid_i(rev_in_valid), .rev_in_data_i(rev_in_data), .rev_in_ready_i(rev_in_ready),
    .rev_out_valid_i(rev_out_valid), .rev_out_data_i(rev_out_data),
    .rev_out_ready_i(rev_out_ready),
    .mismatch_count_o(mismatch_count), .other_count_o(other_count), .pending_o(pending)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic drive_source(input int c, input logic v, input logic [29:0] word);
    if (c < num_ports_lp) begin
      fwd_in_valid[c] = v;
      fwd_in_data[c]  = fwd_pkt_t'(word);
    end else begin
      rev_in_valid[c-num_ports_lp] = v;
      rev_in_data[c-num_ports_lp]  = rev_pkt_t'(word);
    end
  endtask

  task automatic drive_out_ready(input int cycle);
    for (int p = 0; p < num_ports_lp; p++) begin
      fwd_out_ready[p] = (($random(seed) & 3) != 0);
      rev_out_ready[p] = (($random(seed) & 3) != 0);
    end
    // fwd output 1 held off early so its sources back up
    if (cycle < stall_cycles_lp) begin
      fwd_out_ready[1] = 1'b0;
    end
  endtask

  task automatic run_traffic();
    int cycle;
    int hold_cnt [2*num_ports_lp];
    logic [2*num_ports_lp-1:0] accepted;
    logic [2*num_ports_lp-1:0] valid_now;
    logic busy;
    cycle = 0;
    busy = 1'b1;
    for (int c = 0; c < 2 * num_ports_lp; c++) begin
      hold_cnt[c] = 0;
    end
    while (busy && cycle < run_limit_lp) begin
      @(posedge clk);
      accepted = {rev_in_valid & rev_in_ready, fwd_in_valid & fwd_in_ready};
      @(negedge clk);
      valid_now = {rev_in_valid, fwd_in_valid};
      busy = 1'b0;
      for (int c = 0; c < 2 * num_ports_lp; c++) begin
        if (accepted[c]) begin
          void'(ch_list[c].pop_front());
          valid_now[c] = 1'b0;
          hold_cnt[c] = 0;
          drive_source(c, 1'b0, '0);
        end
        if (!valid_now[c] && ch_list[c].size() > 0) begin
          drive_source(c, 1'b1, ch_list[c][0]);
        end else if (valid_now[c]) begin
          hold_cnt[c]++;
          if (hold_cnt[c] == hold_limit_lp) begin
            timeout_errors++;
            $display("timeout: source channel %0d held valid %0d cycles without ready",
                     c, hold_limit_lp);
          end
        end
        if (ch_list[c].size() > 0 && hold_cnt[c] < hold_limit_lp) begin
          busy = 1'b1;
        end
      end
      drive_out_ready(cycle);
      cycle++;
    end
    if (busy) begin
      timeout_errors++;
      $display("timeout: sources still had packets after %0d cycles", run_limit_lp);
    end
  endtask

  task automatic drain_outputs();
    int cycle;
    cycle = 0;
    fwd_out_ready = '1;
    rev_out_ready = '1;
    while (pending != 0 && cycle < hold_limit_lp) begin
      @(negedge clk);
      cycle++;
    end
    if (pending != 0) begin
      timeout_errors++;
      $display("timeout: %0d packets still inside the crossbar", pending);
    end
  endtask

  initial begin
    seed = 81574;
    timeout_errors = 0;
    rst_n = 1'b0;
    fwd_in_valid = '0;
    fwd_in_data = '0;
    fwd_out_ready = '1;
    rev_in_valid = '0;
    rev_in_data = '0;
    rev_out_ready = '1;
    $readmemh("tb/crossbar_patterns.mem", patterns);
    for (int i = 0; i < num_patterns_lp; i++) begin
      ch_list[int'(patterns[i][39:36]) * num_ports_lp + int'(patterns[i][35:32])]
        .push_back(patterns[i][29:0]);
    end
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    run_traffic();
    drain_outputs();
    repeat (2) @(negedge clk);
    chk_i.report_leftovers();
    $display("error counts: mismatches %0d, other %0d, timeouts %0d",
             mismatch_count, other_count, timeout_errors);
    if (mismatch_count == 0 && other_count == 0 && timeout_errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// File: tb/crossbar_patterns.mem
// net(0 fwd, 1 rev) nibble, source port nibble, packet word in 8 hex digits
// fwd: op 2, addr 8, data 16, src y/x, dst y/x   rev: type 2, data 16, dst y/x
0011012341
0022023451
0013034561
0024045672
0111112346
0121112357
0131112364
021222345A
0222223469
0232223478
031333456E
032333457F
033333458D
10000A1233
1000052347
1100061113
1100062220
1200073333
1200074442
1300085553
1300086661

// File: verilog.f
verilog/xbar_geom_pkg.sv
verilog/xbar_pkt_pkg.sv
verilog/link_to_crossbar.sv
verilog/rr_arbiter.sv
verilog/crossbar_o_by_i.sv
verilog/manycore_crossbar.sv
tb/crossbar_checker.sv
tb/crossbar_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the crossbar testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing -f verilog.f --top-module crossbar_tb -Mdir "$OBJ"
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

"./$OBJ/Vcrossbar_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^All checks passed$" "$LOG"; then
  echo "PASS"
  exit 0
else
  echo "FAIL"
  exit 1
fi
